// File: hw/bus_pkg.sv
// bus package: address and data widths, address map and region decode constants
`default_nettype none

package bus_pkg;

  // one bus address and one bus data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // region is the top nibble of the address
  typedef logic [3:0] region_t;

  // address map, one region per slave
  localparam region_t REGION_RAM     = 4'h0;
  localparam region_t REGION_UART    = 4'hB;
  localparam region_t REGION_SYSCTRL = 4'hC;
  localparam region_t REGION_MTIMER  = 4'hF;

  // data ram, 4 KB of words
  localparam int unsigned RAM_WORDS = 1024;
  localparam int unsigned RAM_AW    = 10;

  // register offset taken from address bits 3..0
  // byte offsets of word registers
  localparam int unsigned REG_OFS_W = 4;

endpackage

`default_nettype wire

// File: hw/periph_pkg.sv
// peripheral package: register offsets, reset values and FSM states of the slaves
`default_nettype none

package periph_pkg;

  // system control registers
  localparam logic [3:0]  SYS_BOOT_OFS  = 4'h0;
  localparam logic [3:0]  SYS_CSR_OFS   = 4'h4;
  // core fetch address after reset
  localparam logic [31:0] BOOT_ADDR_RST = 32'h1000_0000;

  // machine timer, low and high words of mtime and mtimecmp
  localparam logic [3:0] MT_TIME_LO_OFS = 4'h0;
  localparam logic [3:0] MT_TIME_HI_OFS = 4'h4;
  localparam logic [3:0] MT_CMP_LO_OFS  = 4'h8;
  localparam logic [3:0] MT_CMP_HI_OFS  = 4'hC;

  // uart transmitter registers
  localparam logic [3:0] UART_DATA_OFS = 4'h0;
  localparam logic [3:0] UART_STAT_OFS = 4'h4;
  localparam logic [3:0] UART_DIV_OFS  = 4'h8;

  // clocks per serial bit
  typedef logic [15:0] div_t;
  localparam div_t UART_DIV_RST = 16'd16;

  // control byte for the board outputs
  typedef logic [7:0] csr_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } uart_state_t;

endpackage

`default_nettype wire

// File: hw/bus_decoder.sv
// bus decoder: routes one master request to a slave by region and merges the responses
`default_nettype none
`timescale 1ns/1ns

module bus_decoder import bus_pkg::*; (
  input  wire        clk,
  input  wire        rst_i,
  // master side request
  input  wire        req_i,
  input  wire        we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  // shared request lines toward the slaves
  output logic       we_o,
  output addr_t      addr_o,
  output data_t      wdata_o,
  // per slave select strobes
  output logic       ram_sel_o,
  output logic       sys_sel_o,
  output logic       mt_sel_o,
  output logic       uart_sel_o,
  // slave responses
  input  wire        ram_rsp_i,
  input  data_t      ram_rdata_i,
  input  wire        sys_rsp_i,
  input  data_t      sys_rdata_i,
  input  wire        mt_rsp_i,
  input  data_t      mt_rdata_i,
  input  wire        uart_rsp_i,
  input  data_t      uart_rdata_i,
  // master side response
  output logic       rsp_o,
  output data_t      rdata_o,
  output logic       err_o
);

  region_t region;
  logic    unmapped;
  logic    unmapped_q;

  assign region = addr_i[31:28];

  // slaves see the bus as is, only the select is decoded
  assign we_o    = we_i;
  assign addr_o  = addr_i;
  assign wdata_o = wdata_i;

  // one select per request, nothing for an unknown region
  always_comb begin
    ram_sel_o  = 1'b0;
    sys_sel_o  = 1'b0;
    mt_sel_o   = 1'b0;
    uart_sel_o = 1'b0;
    unmapped   = 1'b0;
    if (req_i) begin
      case (region)
        REGION_RAM:     ram_sel_o  = 1'b1;
        REGION_SYSCTRL: sys_sel_o  = 1'b1;
        REGION_MTIMER:  mt_sel_o   = 1'b1;
        REGION_UART:    uart_sel_o = 1'b1;
        default:        unmapped   = 1'b1;
      endcase
    end
  end

  // decoder answers unmapped requests itself, same latency as a slave
  always_ff @(posedge clk) begin
    if (rst_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= unmapped;
    end
  end

  assign rsp_o = ram_rsp_i | sys_rsp_i | mt_rsp_i | uart_rsp_i | unmapped_q;
  assign err_o = unmapped_q;

  // read data steered by whichever slave answered
  // zero on an error response
  always_comb begin
    if (ram_rsp_i) begin
      rdata_o = ram_rdata_i;
    end else if (sys_rsp_i) begin
      rdata_o = sys_rdata_i;
    end else if (mt_rsp_i) begin
      rdata_o = mt_rdata_i;
    end else if (uart_rsp_i) begin
      rdata_o = uart_rdata_i;
    end else begin
      rdata_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/ram_slave.sv
// data RAM slave: word memory with a one-cycle registered response
`default_nettype none
`timescale 1ns/1ns

module ram_slave import bus_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  input  wire   sel_i,
  input  wire   we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output logic  rsp_o,
  output data_t rdata_o
);

  data_t             mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;

  // byte address to word index, bits 11..2
  assign word_idx = addr_i[RAM_AW+1:2];

  // write lands on the edge closing the request cycle
  // so a read right after sees it
  always_ff @(posedge clk) begin
    if (sel_i && we_i) begin
      mem[word_idx] <= wdata_i;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      rdata_o <= mem[word_idx];
    end
  end

  // response one cycle after the select
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_o <= 1'b0;
    end else begin
      rsp_o <= sel_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/sys_ctrl.sv
// system control slave: boot address register and eight-bit control output register
`default_nettype none
`timescale 1ns/1ns

module sys_ctrl import bus_pkg::*; import periph_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  input  wire   sel_i,
  input  wire   we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output logic  rsp_o,
  output data_t rdata_o,
  output addr_t boot_addr_o,
  output csr_t  csr_o
);

  logic [REG_OFS_W-1:0] ofs;

  assign ofs = addr_i[REG_OFS_W-1:0];

  // both registers update on the write edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      boot_addr_o <= BOOT_ADDR_RST;
      csr_o       <= '0;
      rsp_o       <= 1'b0;
    end else begin
      rsp_o <= sel_i;
      if (sel_i && we_i) begin
        case (ofs)
          SYS_BOOT_OFS: boot_addr_o <= wdata_i;
          // only the low byte drives the board
          SYS_CSR_OFS:  csr_o       <= wdata_i[7:0];
          default:      ;
        endcase
      end
    end
  end

  // read back, zero for any other offset
  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      case (ofs)
        SYS_BOOT_OFS: rdata_o <= boot_addr_o;
        SYS_CSR_OFS:  rdata_o <= {24'h0, csr_o};
        default:      rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/mtimer_slave.sv
// machine timer slave: 64-bit free-running counter, compare register and level interrupt
`default_nettype none
`timescale 1ns/1ns

module mtimer_slave import bus_pkg::*; import periph_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  input  wire   sel_i,
  input  wire   we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output logic  rsp_o,
  output data_t rdata_o,
  output logic  irq_o
);

  logic [REG_OFS_W-1:0] ofs;
  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic                 wr;

  assign ofs = addr_i[REG_OFS_W-1:0];
  assign wr  = sel_i && we_i;

  // counter runs every cycle, a bus write to a time word wins
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (wr && ofs == MT_TIME_LO_OFS) begin
      mtime_q <= {mtime_q[63:32], wdata_i};
    end else if (wr && ofs == MT_TIME_HI_OFS) begin
      mtime_q <= {wdata_i, mtime_q[31:0]};
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // compare starts at all ones, so no irq out of reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mtimecmp_q <= '1;
    end else if (wr && ofs == MT_CMP_LO_OFS) begin
      mtimecmp_q <= {mtimecmp_q[63:32], wdata_i};
    end else if (wr && ofs == MT_CMP_HI_OFS) begin
      mtimecmp_q <= {wdata_i, mtimecmp_q[31:0]};
    end
  end

  // level irq, registered compare
  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_o <= 1'b0;
      rsp_o <= 1'b0;
    end else begin
      irq_o <= (mtime_q >= mtimecmp_q);
      rsp_o <= sel_i;
    end
  end

  // value seen in the request cycle
  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      case (ofs)
        MT_TIME_LO_OFS: rdata_o <= mtime_q[31:0];
        MT_TIME_HI_OFS: rdata_o <= mtime_q[63:32];
        MT_CMP_LO_OFS:  rdata_o <= mtimecmp_q[31:0];
        MT_CMP_HI_OFS:  rdata_o <= mtimecmp_q[63:32];
        default:        rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_tx_slave.sv
// UART transmitter slave: 8N1 serial output with programmable divisor and overflow flag
`default_nettype none
`timescale 1ns/1ns

module uart_tx_slave import bus_pkg::*; import periph_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  input  wire   sel_i,
  input  wire   we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  output logic  rsp_o,
  output data_t rdata_o,
  output logic  uart_tx_o
);

  logic [REG_OFS_W-1:0] ofs;
  uart_state_t          state_q;
  div_t                 div_q;
  div_t                 div_cnt_q;
  logic [2:0]           bit_cnt_q;
  logic [7:0]           shift_q;
  logic                 ovf_q;
  logic                 busy;
  logic                 bit_end;
  logic                 data_wr;

  assign ofs     = addr_i[REG_OFS_W-1:0];
  assign busy    = (state_q != ST_IDLE);
  assign bit_end = (div_cnt_q == div_q - 16'd1);
  assign data_wr = sel_i && we_i && (ofs == UART_DATA_OFS);

  // frame FSM, line held high when idle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      uart_tx_o <= 1'b1;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      div_cnt_q <= bit_end ? '0 : div_cnt_q + 16'd1;
      case (state_q)
        ST_IDLE: begin
          div_cnt_q <= '0;
          if (data_wr) begin
            // start bit goes out on the next edge
            state_q   <= ST_START;
            uart_tx_o <= 1'b0;
            shift_q   <= wdata_i[7:0];
          end
        end
        ST_START: begin
          if (bit_end) begin
            state_q   <= ST_DATA;
            bit_cnt_q <= '0;
            uart_tx_o <= shift_q[0];
            shift_q   <= shift_q >> 1;
          end
        end
        ST_DATA: begin
          if (bit_end) begin
            if (bit_cnt_q == 3'd7) begin
              // stop bit
              state_q   <= ST_STOP;
              uart_tx_o <= 1'b1;
            end else begin
              // lsb first
              bit_cnt_q <= bit_cnt_q + 3'd1;
              uart_tx_o <= shift_q[0];
              shift_q   <= shift_q >> 1;
            end
          end
        end
        ST_STOP: begin
          if (bit_end) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // divisor and sticky overflow
  always_ff @(posedge clk) begin
    if (rst_i) begin
      div_q <= UART_DIV_RST;
      ovf_q <= 1'b0;
      rsp_o <= 1'b0;
    end else begin
      rsp_o <= sel_i;
      if (sel_i && we_i && ofs == UART_DIV_OFS) begin
        div_q <= wdata_i[15:0];
      end
      // a byte written mid-frame is lost
      if (data_wr && busy) begin
        ovf_q <= 1'b1;
      end else if (sel_i && we_i && ofs == UART_STAT_OFS && wdata_i[1]) begin
        ovf_q <= 1'b0;
      end
    end
  end

  // status: bit 0 busy, bit 1 overflow
  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      case (ofs)
        UART_STAT_OFS: rdata_o <= {30'h0, ovf_q, busy};
        UART_DIV_OFS:  rdata_o <= {16'h0, div_q};
        default:       rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/soc_top.sv
// SoC top level: one bus master port, address decoder, data RAM and three peripherals
`default_nettype none
`timescale 1ns/1ns

module soc_top import bus_pkg::*; import periph_pkg::*; (
  input  wire   clk,
  input  wire   rst_i,
  // master port, driven by the testbench in place of a core
  input  wire   bus_req_i,
  input  wire   bus_we_i,
  input  addr_t bus_addr_i,
  input  data_t bus_wdata_i,
  output logic  bus_rsp_o,
  output data_t bus_rdata_o,
  output logic  bus_err_o,
  // board side
  output addr_t boot_addr_o,
  output csr_t  csr_o,
  output logic  irq_o,
  output logic  uart_tx_o
);

  // shared slave request lines
  logic  slv_we;
  addr_t slv_addr;
  data_t slv_wdata;

  logic  ram_sel;
  logic  sys_sel;
  logic  mt_sel;
  logic  uart_sel;
  logic  ram_rsp;
  logic  sys_rsp;
  logic  mt_rsp;
  logic  uart_rsp;
  data_t ram_rdata;
  data_t sys_rdata;
  data_t mt_rdata;
  data_t uart_rdata;

  bus_decoder u_bus_decoder (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_i        (bus_req_i),
    .we_i         (bus_we_i),
    .addr_i       (bus_addr_i),
    .wdata_i      (bus_wdata_i),
    .we_o         (slv_we),
    .addr_o       (slv_addr),
    .wdata_o      (slv_wdata),
    .ram_sel_o    (ram_sel),
    .sys_sel_o    (sys_sel),
    .mt_sel_o     (mt_sel),
    .uart_sel_o   (uart_sel),
    .ram_rsp_i    (ram_rsp),
    .ram_rdata_i  (ram_rdata),
    .sys_rsp_i    (sys_rsp),
    .sys_rdata_i  (sys_rdata),
    .mt_rsp_i     (mt_rsp),
    .mt_rdata_i   (mt_rdata),
    .uart_rsp_i   (uart_rsp),
    .uart_rdata_i (uart_rdata),
    .rsp_o        (bus_rsp_o),
    .rdata_o      (bus_rdata_o),
    .err_o        (bus_err_o)
  );

  // region 0x0
  ram_slave u_ram_slave (
    .clk     (clk),
    .rst_i   (rst_i),
    .sel_i   (ram_sel),
    .we_i    (slv_we),
    .addr_i  (slv_addr),
    .wdata_i (slv_wdata),
    .rsp_o   (ram_rsp),
    .rdata_o (ram_rdata)
  );

  // region 0xC
  sys_ctrl u_sys_ctrl (
    .clk         (clk),
    .rst_i       (rst_i),
    .sel_i       (sys_sel),
    .we_i        (slv_we),
    .addr_i      (slv_addr),
    .wdata_i     (slv_wdata),
    .rsp_o       (sys_rsp),
    .rdata_o     (sys_rdata),
    .boot_addr_o (boot_addr_o),
    .csr_o       (csr_o)
  );

  // region 0xF
  mtimer_slave u_mtimer_slave (
    .clk     (clk),
    .rst_i   (rst_i),
    .sel_i   (mt_sel),
    .we_i    (slv_we),
    .addr_i  (slv_addr),
    .wdata_i (slv_wdata),
    .rsp_o   (mt_rsp),
    .rdata_o (mt_rdata),
    .irq_o   (irq_o)
  );

  // region 0xB
  uart_tx_slave u_uart_tx_slave (
    .clk       (clk),
    .rst_i     (rst_i),
    .sel_i     (uart_sel),
    .we_i      (slv_we),
    .addr_i    (slv_addr),
    .wdata_i   (slv_wdata),
    .rsp_o     (uart_rsp),
    .rdata_o   (uart_rdata),
    .uart_tx_o (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: tests/soc_checker.sv
// bus checker: concurrent assertions on bus timing, the timer interrupt and the serial line
`default_nettype none
`timescale 1ns/1ns

module soc_checker import bus_pkg::*; (
  input wire   clk,
  input wire   rst_i,
  input wire   req_i,
  input wire   rsp_i,
  input wire   err_i,
  input data_t rdata_i,
  input wire   irq_i,
  input wire   tx_i
);

  // sticky flags, one per assertion
  logic miss_rsp  = 1'b0;
  logic stray_rsp = 1'b0;
  logic bad_err   = 1'b0;
  logic bad_reset = 1'b0;
  logic any_fail;

  assign any_fail = miss_rsp | stray_rsp | bad_err | bad_reset;

  // fixed latency, every request answered on the next edge
  a_rsp_after_req: assert property (@(posedge clk) disable iff (rst_i) req_i |=> rsp_i)
    else begin
      $error("bus request not answered one cycle later");
      miss_rsp = 1'b1;
    end

  // no response without a request one cycle before
  a_rsp_has_req: assert property (@(posedge clk) disable iff (rst_i) rsp_i |-> $past(req_i))
    else begin
      $error("bus response without a request");
      stray_rsp = 1'b1;
    end

  // error only as a response, with zero data
  a_err_in_rsp: assert property (@(posedge clk) disable iff (rst_i)
                                 err_i |-> rsp_i && rdata_i == '0)
    else begin
      $error("bus error outside a response or with nonzero data");
      bad_err = 1'b1;
    end

  // first cycle out of reset: no irq, no response, line idle high
  a_reset_state: assert property (@(posedge clk) $fell(rst_i) |-> !irq_i && !rsp_i && tx_i)
    else begin
      $error("outputs not in their reset state after reset");
      bad_reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_soc_top.sv
// SoC testbench: drives the master port and checks RAM, decoder, sys_ctrl, timer and UART
`default_nettype none
`timescale 1ns/1ns

module tb_soc_top import bus_pkg::*; import periph_pkg::*; ();

  // two uart frames of about 170 cycles and about 300 bus accesses, with margin
  localparam int    TIMEOUT_CYCLES = 6000;
  localparam int    RAM_WRITES     = 64;
  localparam data_t UART_DIV       = 32'd8;

  logic              clk;
  logic              rst_i;
  logic              bus_req_i;
  logic              bus_we_i;
  addr_t             bus_addr_i;
  data_t             bus_wdata_i;
  logic              bus_rsp_o;
  data_t             bus_rdata_o;
  logic              bus_err_o;
  addr_t             boot_addr_o;
  csr_t              csr_o;
  logic              irq_o;
  logic              uart_tx_o;
  // model of the RAM contents and the word indices written
  data_t             ram_model [RAM_WORDS];
  logic [RAM_AW-1:0] written_idx [RAM_WRITES];
  logic [31:0]       rng_state = 32'h8f52_1f62;
  int                cycle_cnt = 0;
  // cycle count seen with the last response
  int                rsp_cycle;

  soc_top u_soc_top (
    .clk         (clk),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rsp_o   (bus_rsp_o),
    .bus_rdata_o (bus_rdata_o),
    .bus_err_o   (bus_err_o),
    .boot_addr_o (boot_addr_o),
    .csr_o       (csr_o),
    .irq_o       (irq_o),
    .uart_tx_o   (uart_tx_o)
  );

  bind soc_top soc_checker u_soc_checker (
    .clk     (clk),
    .rst_i   (rst_i),
    .req_i   (bus_req_i),
    .rsp_i   (bus_rsp_o),
    .err_i   (bus_err_o),
    .rdata_i (bus_rdata_o),
    .irq_i   (irq_o),
    .tx_i    (uart_tx_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // any bound assertion failure ends the run
  always @(negedge clk) begin
    if (u_soc_top.u_soc_checker.any_fail) begin
      $display("a bound bus assertion failed at %0t ns", $time);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure;
    $display("Checks failed");
    $fatal(1, "stopping the run");
  endtask

  task automatic check_value(input data_t got, input data_t exp, input string what);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t reg_addr(input region_t region, input logic [3:0] ofs);
    return {region, 24'h0, ofs};
  endfunction

  function automatic addr_t ram_addr(input logic [RAM_AW-1:0] idx);
    return {REGION_RAM, 16'h0, idx, 2'b00};
  endfunction

  // one request strobe, then wait for the response, sampled on the falling edge
  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    @(posedge clk);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    @(posedge clk);
    bus_req_i   <= 1'b0;
    @(negedge clk);
    while (!bus_rsp_o) begin
      @(negedge clk);
    end
    rdata     = bus_rdata_o;
    err       = bus_err_o;
    rsp_cycle = cycle_cnt;
  endtask

  task automatic bus_write(input addr_t addr, input data_t data);
    data_t rdata;
    logic  err;
    bus_access(1'b1, addr, data, rdata, err);
    check_value({31'h0, err}, 32'h0, "error flag on write");
  endtask

  task automatic bus_read(input addr_t addr, output data_t data);
    logic err;
    bus_access(1'b0, addr, 32'h0, data, err);
    check_value({31'h0, err}, 32'h0, "error flag on read");
  endtask

  task automatic test_sysctrl;
    data_t boot;
    data_t ctrl;
    data_t rdata;
    check_value(boot_addr_o, BOOT_ADDR_RST, "boot address after reset");
    check_value({24'h0, csr_o}, 32'h0, "control byte after reset");
    for (int i = 0; i < 4; i++) begin
      boot = next_rand();
      ctrl = next_rand();
      bus_write(reg_addr(REGION_SYSCTRL, SYS_BOOT_OFS), boot);
      bus_write(reg_addr(REGION_SYSCTRL, SYS_CSR_OFS), ctrl);
      // ports already updated one cycle after the write
      check_value(boot_addr_o, boot, "boot address port");
      check_value({24'h0, csr_o}, {24'h0, ctrl[7:0]}, "control byte port");
      bus_read(reg_addr(REGION_SYSCTRL, SYS_BOOT_OFS), rdata);
      check_value(rdata, boot, "boot address read back");
      bus_read(reg_addr(REGION_SYSCTRL, SYS_CSR_OFS), rdata);
      check_value(rdata, {24'h0, ctrl[7:0]}, "control byte read back");
    end
    // undefined offset reads as zero, no error
    bus_read(reg_addr(REGION_SYSCTRL, 4'h8), rdata);
    check_value(rdata, 32'h0, "undefined sys_ctrl offset");
  endtask

  task automatic test_ram;
    logic [RAM_AW-1:0] idx;
    data_t             r;
    data_t             data;
    for (int i = 0; i < RAM_WRITES; i++) begin
      r              = next_rand();
      idx            = r[RAM_AW-1:0];
      data           = next_rand();
      written_idx[i] = idx;
      ram_model[idx] = data;
      bus_write(ram_addr(idx), data);
    end
    // repeated indices return the last value written
    for (int i = 0; i < RAM_WRITES; i++) begin
      idx = written_idx[i];
      bus_read(ram_addr(idx), data);
      check_value(data, ram_model[idx], "ram word");
    end
  endtask

  task automatic test_decode;
    logic [RAM_AW-1:0] idx;
    data_t             rdata;
    logic              err;
    bus_access(1'b0, 32'h5000_0010, 32'h0, rdata, err);
    check_value({31'h0, err}, 32'h1, "error flag for region 0x5");
    check_value(rdata, 32'h0, "read data on error for region 0x5");
    bus_access(1'b1, 32'hA000_0004, next_rand(), rdata, err);
    check_value({31'h0, err}, 32'h1, "error flag for region 0xA");
    check_value(rdata, 32'h0, "read data on error for region 0xA");
    idx = written_idx[0];
    bus_read(ram_addr(idx), rdata);
    check_value(rdata, ram_model[idx], "ram word after decode error");
  endtask

  task automatic test_timer;
    data_t t0;
    data_t t1;
    int    c0;
    int    c1;
    bus_read(reg_addr(REGION_MTIMER, MT_TIME_LO_OFS), t0);
    c0 = rsp_cycle;
    bus_read(reg_addr(REGION_MTIMER, MT_TIME_LO_OFS), t1);
    c1 = rsp_cycle;
    check_value(t1 - t0, data_t'(c1 - c0), "mtime advance between reads");
    bus_write(reg_addr(REGION_MTIMER, MT_CMP_HI_OFS), 32'h0);
    bus_write(reg_addr(REGION_MTIMER, MT_CMP_LO_OFS), t1 + 32'd40);
    // mtime reaches t1 + 40 forty cycles after the second read
    while (cycle_cnt - c1 < 45) begin
      check_value({31'h0, irq_o}, {31'h0, (cycle_cnt - c1 >= 40)}, "timer irq level");
      @(negedge clk);
    end
    bus_write(reg_addr(REGION_MTIMER, MT_CMP_HI_OFS), 32'hFFFF_FFFF);
    repeat (2) @(negedge clk);
    check_value({31'h0, irq_o}, 32'h0, "timer irq after compare moved away");
  endtask

  task automatic wait_uart_idle;
    data_t rdata;
    bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    while (rdata[0]) begin
      bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    end
  endtask

  task automatic test_uart;
    data_t      r;
    data_t      rdata;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    bus_write(reg_addr(REGION_UART, UART_DIV_OFS), UART_DIV);
    r       = next_rand();
    tx_byte = r[7:0];
    bus_write(reg_addr(REGION_UART, UART_DATA_OFS), {24'h0, tx_byte});
    // falling start edge, then the middle of each bit
    while (uart_tx_o) begin
      @(negedge clk);
    end
    repeat (UART_DIV / 2) @(negedge clk);
    check_value({31'h0, uart_tx_o}, 32'h0, "uart start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (UART_DIV) @(negedge clk);
      rx_byte[i] = uart_tx_o;
    end
    check_value({24'h0, rx_byte}, {24'h0, tx_byte}, "uart data byte");
    repeat (UART_DIV) @(negedge clk);
    check_value({31'h0, uart_tx_o}, 32'h1, "uart stop bit");
    wait_uart_idle();
    // second frame, then a write while busy
    r = next_rand();
    bus_write(reg_addr(REGION_UART, UART_DATA_OFS), {24'h0, r[7:0]});
    bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    check_value(rdata, 32'h1, "uart status while busy");
    bus_write(reg_addr(REGION_UART, UART_DATA_OFS), {24'h0, r[15:8]});
    bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    check_value(rdata, 32'h3, "uart status after overflow");
    bus_write(reg_addr(REGION_UART, UART_STAT_OFS), 32'h2);
    bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    check_value(rdata, 32'h1, "uart status after overflow clear");
    wait_uart_idle();
    bus_read(reg_addr(REGION_UART, UART_STAT_OFS), rdata);
    check_value(rdata, 32'h0, "uart status at end of frame");
  endtask

  initial begin
    rst_i       = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    // sys_ctrl first, its reset values are checked before any write
    test_sysctrl();
    test_ram();
    test_decode();
    test_timer();
    test_uart();
    @(negedge clk);
    if (u_soc_top.u_soc_checker.any_fail) begin
      $display("a bound bus assertion failed during the run");
      stop_with_failure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/bus_decoder.sv
hw/ram_slave.sv
hw/sys_ctrl.sv
hw/mtimer_slave.sv
hw/uart_tx_slave.sv
hw/soc_top.sv
tests/soc_checker.sv
tests/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# build the SoC testbench with Verilator, run it, then search the log for the fail message
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_soc_top \
  -Mdir obj_dir -o tb_soc_top -f verilog.f > build.log 2>&1 ||
  { cat build.log; echo "build error"; exit 1; }
# a failed bound assertion keeps the run going so the testbench can report it
./obj_dir/tb_soc_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation ok"
